// ==== design/beat_params.svh ====
`ifndef BEAT_PARAMS_SVH
`define BEAT_PARAMS_SVH

// chart size and field widths
`define BEAT_NUM_SLOTS      4
`define BEAT_SLOT_W         2
`define BEAT_POS_W          12
`define BEAT_Z_W            14
`define BEAT_TIME_W         18

// note flight, depth in world units
`define BEAT_Z_FAR          1024
`define BEAT_Z_STEP         64
`define BEAT_LIFE           16
`define BEAT_HIT_Z          256
`define BEAT_HALF_SIZE      32

// game pacing and scoring
`define BEAT_TICK_CYCLES    32
`define BEAT_HEALTH_INIT    3
`define BEAT_COMBO_MAX      7
`define BEAT_SCORE_W        12
`define BEAT_HEALTH_W       4
`define BEAT_COMBO_W        3

// apb bus and register map
`define BEAT_APB_ADDR_W     8
`define BEAT_APB_DATA_W     32
`define BEAT_ADDR_CTRL      'h00
`define BEAT_ADDR_STATUS    'h04
`define BEAT_ADDR_TIME      'h08
`define BEAT_ADDR_SLOT_BASE 'h20

`endif

// ==== design/beat_pkg.sv ====
`include "beat_params.svh"

package beat_pkg;

    //////////////////////////////
    // game state

    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        PLAYING = 2'd1,
        OVER    = 2'd2
    } game_state_t;

    //////////////////////////////
    // chart entry, one per slot

    typedef struct packed {
        logic                    enable;
        logic                    colour;
        logic [`BEAT_POS_W-1:0]  x;
        logic [`BEAT_POS_W-1:0]  y;
        logic [`BEAT_TIME_W-1:0] spawn;
    } note_entry_t;

    //////////////////////////////
    // stage payloads

    // mover to checker
    typedef struct packed {
        logic [`BEAT_SLOT_W-1:0] slot;
        logic                    colour;
        logic [`BEAT_POS_W-1:0]  x;
        logic [`BEAT_POS_W-1:0]  y;
        logic [`BEAT_Z_W-1:0]    depth;
        logic                    visible;
        logic                    at_player;
    } note_view_t;

    // checker to score keeper
    typedef struct packed {
        logic [`BEAT_SLOT_W-1:0] slot;
        logic                    sliced;
        logic                    missed;
    } note_event_t;

endpackage

// ==== design/stage_if.sv ====
`timescale 1ns/10ps

// one pipeline hop, no back-pressure
interface stage_if #(
    parameter type T = logic
);

    logic valid;
    T     payload;

    // producer side
    modport source (
        output valid,
        output payload
    );

    // consumer side
    modport sink (
        input valid,
        input payload
    );

endinterface

// ==== design/chart_regs.sv ====
`timescale 1ns/10ps
`include "beat_params.svh"

module chart_regs import beat_pkg::*; (
    input  logic                            clk_in,
    input  logic                            rst_in,
    input  logic [`BEAT_APB_ADDR_W-1:0]     paddr,
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [`BEAT_APB_DATA_W-1:0]     pwdata,
    output logic [`BEAT_APB_DATA_W-1:0]     prdata,
    output logic                            pready,
    output logic                            pslverr,
    input  game_state_t                     game_state,
    input  logic [`BEAT_SCORE_W-1:0]        score,
    input  logic [`BEAT_HEALTH_W-1:0]       health,
    input  logic [`BEAT_COMBO_W-1:0]        combo,
    input  logic [`BEAT_TIME_W-1:0]         curr_time,
    output note_entry_t                     chart [`BEAT_NUM_SLOTS],
    output logic                            start
);

    localparam logic [`BEAT_APB_ADDR_W-1:0] ADDR_CTRL      = `BEAT_ADDR_CTRL;
    localparam logic [`BEAT_APB_ADDR_W-1:0] ADDR_STATUS    = `BEAT_ADDR_STATUS;
    localparam logic [`BEAT_APB_ADDR_W-1:0] ADDR_TIME      = `BEAT_ADDR_TIME;
    localparam logic [`BEAT_APB_ADDR_W-1:0] ADDR_SLOT_BASE = `BEAT_ADDR_SLOT_BASE;

    logic                          access;
    logic                          wr_en;
    logic [`BEAT_APB_ADDR_W-1:0]   slot_off;
    logic                          is_slot;
    logic                          mapped;
    logic [`BEAT_SLOT_W-1:0]       slot_sel;
    logic                          word_b;
    logic [`BEAT_APB_DATA_W-1:0]   slot_rdata;
    logic [`BEAT_APB_DATA_W-1:0]   status_word;

    //////////////////////////////
    // address decode

    assign access = psel && penable;
    assign wr_en  = access && pwrite && mapped;

    // 8 bytes per slot, word b at +4
    assign slot_off = paddr - ADDR_SLOT_BASE;
    assign slot_sel = slot_off[`BEAT_SLOT_W+2:3];
    assign word_b   = slot_off[2];
    assign is_slot  = (paddr >= ADDR_SLOT_BASE)
                   && (slot_off[`BEAT_APB_ADDR_W-1:`BEAT_SLOT_W+3] == '0);

    assign mapped = (paddr[1:0] == 2'b00)
                 && ((paddr == ADDR_CTRL) || (paddr == ADDR_STATUS)
                     || (paddr == ADDR_TIME) || is_slot);

    // zero wait states
    assign pready  = 1'b1;
    assign pslverr = access && !mapped;

    //////////////////////////////
    // writes

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            start <= 1'b0;
            for (int i = 0; i < `BEAT_NUM_SLOTS; i++) begin
                chart[i] <= '0;
            end
        end else begin
            // single cycle pulse
            start <= wr_en && (paddr == ADDR_CTRL) && pwdata[0];
            if (wr_en && is_slot) begin
                if (word_b) begin
                    chart[slot_sel].spawn <= pwdata[`BEAT_TIME_W-1:0];
                end else begin
                    chart[slot_sel].x      <= pwdata[`BEAT_POS_W-1:0];
                    chart[slot_sel].y      <= pwdata[2*`BEAT_POS_W-1:`BEAT_POS_W];
                    chart[slot_sel].colour <= pwdata[24];
                    chart[slot_sel].enable <= pwdata[25];
                end
            end
        end
    end

    //////////////////////////////
    // read mux

    always_comb begin
        status_word        = '0;
        status_word[11:0]  = score;
        status_word[15:12] = health;
        status_word[18:16] = combo;
        status_word[21:20] = game_state;

        slot_rdata = '0;
        if (word_b) begin
            slot_rdata[`BEAT_TIME_W-1:0] = chart[slot_sel].spawn;
        end else begin
            slot_rdata[`BEAT_POS_W-1:0]            = chart[slot_sel].x;
            slot_rdata[2*`BEAT_POS_W-1:`BEAT_POS_W] = chart[slot_sel].y;
            slot_rdata[24]                         = chart[slot_sel].colour;
            slot_rdata[25]                         = chart[slot_sel].enable;
        end

        prdata = '0;
        if (paddr == ADDR_STATUS) begin
            prdata = status_word;
        end else if (paddr == ADDR_TIME) begin
            prdata[`BEAT_TIME_W-1:0] = curr_time;
        end else if (is_slot) begin
            prdata = slot_rdata;
        end
    end

    // access phase only inside a selected transfer
    assert property (@(posedge clk_in) disable iff (rst_in) penable |-> psel)
        else $error("penable seen without psel");

endmodule

// ==== design/note_mover.sv ====
`timescale 1ns/10ps
`include "beat_params.svh"

module note_mover import beat_pkg::*; (
    input  logic                     clk_in,
    input  logic                     rst_in,
    input  logic                     start,
    input  game_state_t              game_state,
    input  note_entry_t              chart [`BEAT_NUM_SLOTS],
    output logic [`BEAT_TIME_W-1:0]  curr_time,
    stage_if.source                  view_out
);

    localparam int DIV_W = $clog2(`BEAT_TICK_CYCLES);
    localparam logic [`BEAT_Z_W-1:0] Z_FAR  = `BEAT_Z_FAR;
    localparam logic [`BEAT_Z_W-1:0] Z_STEP = `BEAT_Z_STEP;

    logic [DIV_W-1:0]         div_cnt;
    logic                     tick;
    logic                     scan_on;
    logic [`BEAT_SLOT_W-1:0]  scan_idx;
    note_entry_t              entry;
    logic                     spawned;
    logic [`BEAT_TIME_W-1:0]  elapsed;
    note_view_t               view;

    //////////////////////////////
    // game clock

    assign tick = (game_state == PLAYING) && (div_cnt == DIV_W'(`BEAT_TICK_CYCLES - 1));

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            div_cnt   <= '0;
            curr_time <= '0;
            scan_on   <= 1'b0;
            scan_idx  <= '0;
        end else if (start) begin
            // time 0 gets its own pass
            div_cnt   <= '0;
            curr_time <= '0;
            scan_on   <= 1'b1;
            scan_idx  <= '0;
        end else if (tick) begin
            div_cnt   <= '0;
            curr_time <= curr_time + 1;
            scan_on   <= 1'b1;
            scan_idx  <= '0;
        end else begin
            if (game_state == PLAYING) begin
                div_cnt <= div_cnt + 1;
            end
            // one slot per cycle, stop after the last
            if (scan_on) begin
                scan_idx <= scan_idx + 1;
                if (scan_idx == `BEAT_SLOT_W'(`BEAT_NUM_SLOTS - 1)) begin
                    scan_on <= 1'b0;
                end
            end
        end
    end

    //////////////////////////////
    // per slot depth

    always_comb begin
        entry   = chart[scan_idx];
        spawned = curr_time >= entry.spawn;
        elapsed = curr_time - entry.spawn;

        view.slot      = scan_idx;
        view.colour    = entry.colour;
        view.x         = entry.x;
        view.y         = entry.y;
        view.visible   = entry.enable && spawned && (elapsed <= `BEAT_LIFE);
        view.at_player = view.visible && (elapsed == `BEAT_LIFE);
        // hidden notes park at the far plane
        view.depth     = view.visible ? Z_FAR - elapsed[`BEAT_Z_W-1:0] * Z_STEP : Z_FAR;
    end

    // scan is cut off as soon as the game leaves play
    assign view_out.valid   = scan_on && (game_state == PLAYING);
    assign view_out.payload = view;

    // the slot scan fits inside one tick
    assert property (@(posedge clk_in) disable iff (rst_in) tick |-> !scan_on)
        else $error("tick arrived before the slot scan finished");

endmodule

// ==== design/slice_checker.sv ====
`timescale 1ns/10ps
`include "beat_params.svh"

module slice_checker import beat_pkg::*; (
    input  logic                    clk_in,
    input  logic                    rst_in,
    input  logic                    start,
    input  logic [`BEAT_POS_W-1:0]  left_x,
    input  logic [`BEAT_POS_W-1:0]  left_y,
    input  logic [`BEAT_POS_W-1:0]  right_x,
    input  logic [`BEAT_POS_W-1:0]  right_y,
    stage_if.sink                   view_in,
    stage_if.source                 event_out
);

    logic [`BEAT_NUM_SLOTS-1:0]  sliced_mask;
    note_view_t                  view;
    logic [`BEAT_POS_W-1:0]      hand_x;
    logic [`BEAT_POS_W-1:0]      hand_y;
    logic                        fresh;
    logic                        in_reach;
    logic                        in_box;
    logic                        hit;
    logic                        miss;
    note_event_t                 evt;

    function automatic logic [`BEAT_POS_W-1:0] abs_diff(
        input logic [`BEAT_POS_W-1:0] a,
        input logic [`BEAT_POS_W-1:0] b
    );
        return (a > b) ? a - b : b - a;
    endfunction

    always_comb begin
        view = view_in.payload;
        // colour 0 is the left hand
        hand_x = view.colour ? right_x : left_x;
        hand_y = view.colour ? right_y : left_y;

        fresh    = view.visible && !sliced_mask[view.slot];
        in_reach = view.depth <= `BEAT_HIT_Z;
        in_box   = (abs_diff(hand_x, view.x) < `BEAT_HALF_SIZE)
                && (abs_diff(hand_y, view.y) < `BEAT_HALF_SIZE);
        hit      = fresh && in_reach && in_box;
        // slice wins over miss on the last item
        miss     = fresh && view.at_player && !hit;

        evt.slot   = view.slot;
        evt.sliced = hit;
        evt.missed = miss;
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            event_out.valid <= 1'b0;
            sliced_mask     <= '0;
        end else begin
            event_out.valid <= view_in.valid;
            if (start) begin
                sliced_mask <= '0;
            end else if (view_in.valid && hit) begin
                sliced_mask[view.slot] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        event_out.payload <= evt;
    end

    // a note at the player is still within slicing depth
    assert property (@(posedge clk_in) disable iff (rst_in)
        view_in.valid && view.at_player |-> in_reach)
        else $error("note reached the player beyond slicing depth");

endmodule

// ==== design/score_keeper.sv ====
`timescale 1ns/10ps
`include "beat_params.svh"

module score_keeper import beat_pkg::*; (
    input  logic                       clk_in,
    input  logic                       rst_in,
    input  logic                       start,
    stage_if.sink                      event_in,
    output logic [`BEAT_SCORE_W-1:0]   score,
    output logic [`BEAT_HEALTH_W-1:0]  health,
    output logic [`BEAT_COMBO_W-1:0]   combo,
    output game_state_t                game_state
);

    note_event_t                 evt;
    logic                        take;
    logic [`BEAT_SCORE_W-1:0]    combo_wide;

    //////////////////////////////
    // event qualify

    assign evt  = event_in.payload;
    // nothing counts outside play
    assign take = event_in.valid && (game_state == PLAYING);

    assign combo_wide = {{(`BEAT_SCORE_W - `BEAT_COMBO_W){1'b0}}, combo};

    //////////////////////////////
    // score, combo, health, state

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            game_state <= IDLE;
            score      <= '0;
            health     <= '0;
            combo      <= '0;
        end else if (start) begin
            game_state <= PLAYING;
            score      <= '0;
            health     <= `BEAT_HEALTH_INIT;
            combo      <= '0;
        end else if (take && evt.sliced) begin
            // bonus grows with the running combo
            score <= score + combo_wide + 1;
            if (combo != `BEAT_COMBO_MAX) begin
                combo <= combo + 1;
            end
        end else if (take && evt.missed) begin
            combo  <= '0;
            health <= health - 1;
            // last life gone, game clock stops
            if (health == 1) begin
                game_state <= OVER;
            end
        end
    end

endmodule

// ==== design/beat_core.sv ====
`timescale 1ns/10ps
`include "beat_params.svh"

module beat_core import beat_pkg::*; (
    input  logic                         clk_in,
    input  logic                         rst_in,

    // apb slave
    input  logic [`BEAT_APB_ADDR_W-1:0]  paddr,
    input  logic                         psel,
    input  logic                         penable,
    input  logic                         pwrite,
    input  logic [`BEAT_APB_DATA_W-1:0]  pwdata,
    output logic [`BEAT_APB_DATA_W-1:0]  prdata,
    output logic                         pready,
    output logic                         pslverr,

    // saber tips
    input  logic [`BEAT_POS_W-1:0]       left_x,
    input  logic [`BEAT_POS_W-1:0]       left_y,
    input  logic [`BEAT_POS_W-1:0]       right_x,
    input  logic [`BEAT_POS_W-1:0]       right_y,

    // game status
    output logic [`BEAT_SCORE_W-1:0]     score,
    output logic [`BEAT_HEALTH_W-1:0]    health,
    output logic [`BEAT_COMBO_W-1:0]     combo,
    output game_state_t                  game_state
);

    note_entry_t               chart [`BEAT_NUM_SLOTS];
    logic                      start;
    logic [`BEAT_TIME_W-1:0]   curr_time;

    stage_if #(.T(note_view_t))  view_if ();
    stage_if #(.T(note_event_t)) event_if ();

    //////////////////////////////
    // host side

    chart_regs i_chart_regs (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .paddr      (paddr),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .game_state (game_state),
        .score      (score),
        .health     (health),
        .combo      (combo),
        .curr_time  (curr_time),
        .chart      (chart),
        .start      (start)
    );

    //////////////////////////////
    // three stage pipeline

    note_mover i_note_mover (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .start      (start),
        .game_state (game_state),
        .chart      (chart),
        .curr_time  (curr_time),
        .view_out   (view_if.source)
    );

    slice_checker i_slice_checker (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .start      (start),
        .left_x     (left_x),
        .left_y     (left_y),
        .right_x    (right_x),
        .right_y    (right_y),
        .view_in    (view_if.sink),
        .event_out  (event_if.source)
    );

    score_keeper i_score_keeper (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .start      (start),
        .event_in   (event_if.sink),
        .score      (score),
        .health     (health),
        .combo      (combo),
        .game_state (game_state)
    );

endmodule

// ==== bench/tb_beat_core.sv ====
`timescale 1ns/10ps
`include "beat_params.svh"

module tb_beat_core import beat_pkg::*; ();

    localparam int N_ROWS = 5;
    localparam int CLK_NS = 20;

    logic                          clk_in;
    logic                          rst_in;
    logic [`BEAT_APB_ADDR_W-1:0]   paddr;
    logic                          psel;
    logic                          penable;
    logic                          pwrite;
    logic [`BEAT_APB_DATA_W-1:0]   pwdata;
    logic [`BEAT_APB_DATA_W-1:0]   prdata;
    logic                          pready;
    logic                          pslverr;
    logic [`BEAT_POS_W-1:0]        left_x;
    logic [`BEAT_POS_W-1:0]        left_y;
    logic [`BEAT_POS_W-1:0]        right_x;
    logic [`BEAT_POS_W-1:0]        right_y;
    logic [`BEAT_SCORE_W-1:0]      score;
    logic [`BEAT_HEALTH_W-1:0]     health;
    logic [`BEAT_COMBO_W-1:0]      combo;
    game_state_t                   game_state;

    // one row per game, hands are left x, left y, right x, right y
    note_entry_t                   tbl_notes  [N_ROWS][`BEAT_NUM_SLOTS];
    logic [`BEAT_POS_W-1:0]        tbl_hands  [N_ROWS][4];
    int                            tbl_end    [N_ROWS];
    int                            tbl_score  [N_ROWS];
    int                            tbl_health [N_ROWS];
    int                            tbl_combo  [N_ROWS];
    game_state_t                   tbl_state  [N_ROWS];

    beat_core i_dut (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .paddr      (paddr),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .left_x     (left_x),
        .left_y     (left_y),
        .right_x    (right_x),
        .right_y    (right_y),
        .score      (score),
        .health     (health),
        .combo      (combo),
        .game_state (game_state)
    );

    initial begin
        clk_in = 1'b0;
        forever #(CLK_NS / 2) clk_in = ~clk_in;
    end

    //////////////////////////////
    // helpers

    task automatic check_val(input string name, input int exp, input int act);
        assert (act == exp) else begin
            $display("FAILED time=%0t %s expected=%0d actual=%0d", $time, name, exp, act);
            $display("TESTS FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    function automatic int abs_dist(input int a, input int b);
        return (a > b) ? a - b : b - a;
    endfunction

    function automatic note_entry_t make_note(input int col, input int x, input int y,
                                              input int spawn);
        note_entry_t n;
        n.enable = 1'b1;
        n.colour = col[0];
        n.x      = x[`BEAT_POS_W-1:0];
        n.y      = y[`BEAT_POS_W-1:0];
        n.spawn  = spawn[`BEAT_TIME_W-1:0];
        return n;
    endfunction

    // all slots start disabled
    task automatic set_row(input int r, input int lx, input int ly, input int rx, input int ry,
                           input int end_t, input int sc, input int he, input int co,
                           input game_state_t st);
        for (int s = 0; s < `BEAT_NUM_SLOTS; s++) begin
            tbl_notes[r][s] = '0;
        end
        tbl_hands[r][0] = lx[`BEAT_POS_W-1:0];
        tbl_hands[r][1] = ly[`BEAT_POS_W-1:0];
        tbl_hands[r][2] = rx[`BEAT_POS_W-1:0];
        tbl_hands[r][3] = ry[`BEAT_POS_W-1:0];
        tbl_end[r]    = end_t;
        tbl_score[r]  = sc;
        tbl_health[r] = he;
        tbl_combo[r]  = co;
        tbl_state[r]  = st;
    endtask

    task automatic load_table();
        // single slice with the own hand
        set_row(0, 100, 200, 900, 900, 18, 1, 3, 1, PLAYING);
        tbl_notes[0][0] = make_note(0, 100, 200, 1);
        // wrong hand and an edge offset, after one slice
        set_row(1, 0, 0, 300, 300, 20, 1, 1, 0, PLAYING);
        tbl_notes[1][0] = make_note(0, 300, 300, 0);
        tbl_notes[1][1] = make_note(1, 332, 300, 2);
        tbl_notes[1][2] = make_note(1, 310, 290, 0);
        // staggered combo
        set_row(2, 400, 400, 0, 0, 18, 6, 3, 3, PLAYING);
        tbl_notes[2][0] = make_note(0, 400, 400, 0);
        tbl_notes[2][1] = make_note(0, 400, 400, 2);
        tbl_notes[2][2] = make_note(0, 400, 400, 4);
        // same combo then a miss
        set_row(3, 400, 400, 0, 0, 24, 6, 2, 0, PLAYING);
        tbl_notes[3][0] = make_note(0, 400, 400, 0);
        tbl_notes[3][1] = make_note(0, 400, 400, 2);
        tbl_notes[3][2] = make_note(0, 400, 400, 4);
        tbl_notes[3][3] = make_note(1, 1000, 1000, 6);
        // three misses end the game
        set_row(4, 2000, 2000, 100, 100, 30, 0, 0, 0, OVER);
        tbl_notes[4][0] = make_note(0, 100, 100, 0);
        tbl_notes[4][1] = make_note(0, 100, 100, 1);
        tbl_notes[4][2] = make_note(0, 100, 100, 2);
    endtask

    //////////////////////////////
    // reference model, one pass per game tick

    task automatic run_model(input int r, output int m_score, output int m_health,
                             output int m_combo, output game_state_t m_state,
                             output int m_time);
        logic        sliced [`BEAT_NUM_SLOTS];
        note_entry_t n;
        int          elapsed;
        int          depth;
        int          hx;
        int          hy;
        m_score  = 0;
        m_health = `BEAT_HEALTH_INIT;
        m_combo  = 0;
        m_state  = PLAYING;
        m_time   = tbl_end[r];
        for (int s = 0; s < `BEAT_NUM_SLOTS; s++) begin
            sliced[s] = 1'b0;
        end
        for (int t = 0; t <= tbl_end[r] && m_state == PLAYING; t++) begin
            for (int s = 0; s < `BEAT_NUM_SLOTS; s++) begin
                n       = tbl_notes[r][s];
                elapsed = t - int'(n.spawn);
                if (m_state == PLAYING && n.enable && !sliced[s]
                    && elapsed >= 0 && elapsed <= `BEAT_LIFE) begin
                    depth = `BEAT_Z_FAR - elapsed * `BEAT_Z_STEP;
                    hx    = n.colour ? tbl_hands[r][2] : tbl_hands[r][0];
                    hy    = n.colour ? tbl_hands[r][3] : tbl_hands[r][1];
                    if (depth <= `BEAT_HIT_Z && abs_dist(hx, n.x) < `BEAT_HALF_SIZE
                        && abs_dist(hy, n.y) < `BEAT_HALF_SIZE) begin
                        sliced[s] = 1'b1;
                        m_score   = m_score + 1 + m_combo;
                        if (m_combo < `BEAT_COMBO_MAX) begin
                            m_combo = m_combo + 1;
                        end
                    end else if (elapsed == `BEAT_LIFE) begin
                        m_combo  = 0;
                        m_health = m_health - 1;
                        if (m_health == 0) begin
                            m_state = OVER;
                            m_time  = t;
                        end
                    end
                end
            end
        end
    endtask

    //////////////////////////////
    // apb and reset

    task automatic apb_write(input int addr, input logic [31:0] data, input int exp_err);
        @(posedge clk_in);
        #2;
        paddr   = addr[`BEAT_APB_ADDR_W-1:0];
        pwdata  = data;
        pwrite  = 1'b1;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge clk_in);
        #2;
        penable = 1'b1;
        @(negedge clk_in);
        check_val("pslverr", exp_err, pslverr);
        check_val("pready", 1, pready);
        @(posedge clk_in);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input int addr, input int exp_err, output logic [31:0] data);
        @(posedge clk_in);
        #2;
        paddr   = addr[`BEAT_APB_ADDR_W-1:0];
        pwrite  = 1'b0;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge clk_in);
        #2;
        penable = 1'b1;
        @(negedge clk_in);
        data = prdata;
        check_val("pslverr", exp_err, pslverr);
        check_val("pready", 1, pready);
        @(posedge clk_in);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apply_reset();
        @(posedge clk_in);
        #2;
        rst_in = 1'b1;
        repeat (2) @(posedge clk_in);
        #2;
        rst_in = 1'b0;
    endtask

    //////////////////////////////
    // scenario loop

    initial begin : main
        logic [31:0]  rdata;
        logic [31:0]  st_word;
        logic [31:0]  t_now;
        logic [31:0]  t_later;
        int           m_score;
        int           m_health;
        int           m_combo;
        int           m_time;
        game_state_t  m_state;
        rst_in  = 1'b1;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        left_x  = '0;
        left_y  = '0;
        right_x = '0;
        right_y = '0;
        load_table();

        for (int r = 0; r < N_ROWS; r++) begin
            run_model(r, m_score, m_health, m_combo, m_state, m_time);
            check_val("model score", tbl_score[r], m_score);
            check_val("model health", tbl_health[r], m_health);
            check_val("model combo", tbl_combo[r], m_combo);
            check_val("model state", tbl_state[r], m_state);

            apply_reset();
            check_val("game_state", IDLE, game_state);
            check_val("score", 0, score);
            check_val("combo", 0, combo);
            check_val("health", 0, health);

            for (int s = 0; s < `BEAT_NUM_SLOTS; s++) begin
                apb_write(`BEAT_ADDR_SLOT_BASE + 8 * s,
                          {6'd0, tbl_notes[r][s].enable, tbl_notes[r][s].colour,
                           tbl_notes[r][s].y, tbl_notes[r][s].x}, 0);
                apb_write(`BEAT_ADDR_SLOT_BASE + 8 * s + 4, 32'(tbl_notes[r][s].spawn), 0);
            end
            @(posedge clk_in);
            #2;
            left_x  = tbl_hands[r][0];
            left_y  = tbl_hands[r][1];
            right_x = tbl_hands[r][2];
            right_y = tbl_hands[r][3];

            apb_write(`BEAT_ADDR_CTRL, 32'h1, 0);
            apb_read(`BEAT_ADDR_STATUS, 0, st_word);
            check_val("status state after start", PLAYING, st_word[21:20]);
            check_val("status health after start", `BEAT_HEALTH_INIT, st_word[15:12]);

            // wait for the end tick or game over
            apb_read(`BEAT_ADDR_TIME, 0, t_now);
            apb_read(`BEAT_ADDR_STATUS, 0, st_word);
            while (t_now < tbl_end[r] && st_word[21:20] != OVER) begin
                apb_read(`BEAT_ADDR_TIME, 0, t_now);
                apb_read(`BEAT_ADDR_STATUS, 0, st_word);
            end
            // last slot settles a few cycles after its tick
            if (st_word[21:20] != OVER) begin
                repeat (`BEAT_TICK_CYCLES / 2) @(posedge clk_in);
            end

            apb_read(`BEAT_ADDR_TIME, 0, t_now);
            apb_read(`BEAT_ADDR_STATUS, 0, st_word);
            check_val("time", m_time, t_now);
            check_val("status score", m_score, st_word[11:0]);
            check_val("status health", m_health, st_word[15:12]);
            check_val("status combo", m_combo, st_word[18:16]);
            check_val("status state", m_state, st_word[21:20]);
            check_val("score", st_word[11:0], score);
            check_val("health", st_word[15:12], health);
            check_val("combo", st_word[18:16], combo);
            check_val("game_state", st_word[21:20], game_state);

            // clock frozen once the game is over
            if (m_state == OVER) begin
                repeat (2 * `BEAT_TICK_CYCLES) @(posedge clk_in);
                apb_read(`BEAT_ADDR_TIME, 0, t_later);
                check_val("time after over", t_now, t_later);
            end
        end

        // unmapped accesses leave registers alone
        apb_read(`BEAT_ADDR_SLOT_BASE, 0, rdata);
        check_val("slot 0 readback",
                  {6'd0, tbl_notes[N_ROWS-1][0].enable, tbl_notes[N_ROWS-1][0].colour,
                   tbl_notes[N_ROWS-1][0].y, tbl_notes[N_ROWS-1][0].x}, rdata);
        apb_write(`BEAT_ADDR_SLOT_BASE + 1, 32'h03ff_ffff, 1);
        apb_write(`BEAT_ADDR_SLOT_BASE + 8 * `BEAT_NUM_SLOTS, 32'h0300_0000, 1);
        apb_write(`BEAT_ADDR_CTRL + 1, 32'h1, 1);
        apb_read(`BEAT_ADDR_SLOT_BASE + 8 * `BEAT_NUM_SLOTS, 1, t_now);
        apb_read('h10, 1, t_now);
        apb_read(`BEAT_ADDR_SLOT_BASE, 0, t_later);
        check_val("slot 0 word a", rdata, t_later);
        apb_read(`BEAT_ADDR_STATUS, 0, st_word);
        check_val("status state after bad ctrl", OVER, st_word[21:20]);

        $display("TESTS PASSED");
        $finish;
    end

    //////////////////////////////
    // watchdog

    initial begin : watchdog
        longint limit_ns;
        int     max_end;
        #1;
        max_end = 0;
        for (int r = 0; r < N_ROWS; r++) begin
            if (tbl_end[r] > max_end) begin
                max_end = tbl_end[r];
            end
        end
        limit_ns = longint'(N_ROWS) * (max_end + 4) * `BEAT_TICK_CYCLES * CLK_NS;
        #(limit_ns);
        $display("watchdog expired before all games finished");
        $display("TESTS FAILED");
        $fatal(1, "timeout");
    end

endmodule

// ==== src.f ====
+incdir+design
design/beat_pkg.sv
design/stage_if.sv
design/chart_regs.sv
design/note_mover.sv
design/slice_checker.sv
design/score_keeper.sv
design/beat_core.sv
bench/tb_beat_core.sv

// ==== Makefile ====
# Verilator simulation of the beat_core testbench

VERILATOR ?= verilator
TOP       ?= tb_beat_core
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: sim clean

# pass only when the run prints the pass message
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf $(BUILD_DIR)
